// File: Makefile
# Verilator build for the audio output path

VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = tb_audio_out
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_audio_out.sv
// Audio output path testbench
`timescale 1ns/10ps
`default_nettype none

`include "audio_cfg.svh"

module tb_audio_out;

	localparam int SEED = 35867;

	logic               clk_sys;
	logic               reset;
	logic signed [15:0] sb_left;
	logic signed [15:0] sb_right;
	logic               speaker;
	logic [1:0]         speaker_volume;
	logic signed [15:0] synth_left;
	logic signed [15:0] synth_right;
	logic               synth_mute;
	logic [1:0]         comp_mode;
	logic               mix_strobe;
	logic signed [15:0] audio_left;
	logic signed [15:0] audio_right;
	logic               audio_strobe;

	logic [15:0]        lfsr;
	logic [31:0]        exp_q [$];
	logic signed [15:0] model_sb_l;
	logic signed [15:0] model_sb_r;
	logic [2:0]         strobe_hist;
	logic [15:0]        last_left;
	logic [15:0]        last_right;
	int                 errors;
	int                 mon_errors;
	int                 timeouts;

	audio_out_top i_audio_out_top (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.sb_left        (sb_left),
		.sb_right       (sb_right),
		.speaker        (speaker),
		.speaker_volume (speaker_volume),
		.synth_left     (synth_left),
		.synth_right    (synth_right),
		.synth_mute     (synth_mute),
		.comp_mode      (comp_mode),
		.mix_strobe     (mix_strobe),
		.audio_left     (audio_left),
		.audio_right    (audio_right),
		.audio_strobe   (audio_strobe)
	);

	always #5 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////
	// Random numbers and reference model
	//////////////////////////////////////////////////

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Wrap to the 17-bit sum, then clip to 16 bits
	function automatic logic signed [15:0] clip_sum(input int s);
		logic signed [16:0] t;
		int w;
		t = 17'(s);
		w = int'(t);
		if (w > 32767) return 16'sh7FFF;
		if (w < -32768) return 16'sh8000;
		return 16'(w);
	endfunction

	function automatic logic signed [15:0] curve(input logic signed [15:0] s,
		input logic [1:0] mode);
		int mag;
		int x;
		int a;
		int f;
		int c;
		if (mode == 2'd0) return s;
		x = (mode == 2'd1) ? `COMP_LIGHT_X : `COMP_HEAVY_X;
		a = (mode == 2'd1) ? `COMP_LIGHT_A : `COMP_HEAVY_A;
		f = (mode == 2'd1) ? `COMP_LIGHT_F : `COMP_HEAVY_F;
		mag = s[15] ? -int'(s) : int'(s);
		c = (mag < x) ? mag * a : (mag - x) / f + x * a;
		return s[15] ? 16'(-c) : 16'(c);
	endfunction

	// Expected {left, right} for the sound card pair the model holds
	function automatic logic [31:0] model_pair(input logic spk, input logic [1:0] vol,
		input logic signed [15:0] syl, input logic signed [15:0] syr,
		input logic mute, input logic [1:0] mode);
		int spk_term;
		int l;
		int r;
		spk_term = spk ? (1 << (int'(vol) + `AUDIO_SPK_SHIFT)) : 0;
		l = int'(model_sb_l) + spk_term + (mute ? 0 : int'(syl));
		r = int'(model_sb_r) + spk_term + (mute ? 0 : int'(syr));
		return {curve(clip_sum(l), mode), curve(clip_sum(r), mode)};
	endfunction

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	// Four cycles covers the filter's three-edge settle
	task automatic set_sb(input logic signed [15:0] l, input logic signed [15:0] r);
		@(posedge clk_sys);
		sb_left  <= l;
		sb_right <= r;
		repeat (4) @(posedge clk_sys);
		model_sb_l = l;
		model_sb_r = r;
	endtask

	task automatic strobe_one(input logic spk, input logic [1:0] vol,
		input logic signed [15:0] syl, input logic signed [15:0] syr,
		input logic mute, input logic [1:0] mode, input logic [31:0] expected);
		@(posedge clk_sys);
		speaker        <= spk;
		speaker_volume <= vol;
		synth_left     <= syl;
		synth_right    <= syr;
		synth_mute     <= mute;
		comp_mode      <= mode;
		mix_strobe     <= 1'b1;
		exp_q.push_back(expected);
	endtask

	task automatic end_strobes();
		@(posedge clk_sys);
		mix_strobe <= 1'b0;
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 20) begin
			@(posedge clk_sys);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("Timeout: %0d samples never reached the output", exp_q.size());
			timeouts++;
			exp_q.delete();
		end
	endtask

	// Bursts of one to four strobes on random inputs
	task automatic random_mixes(input int count, input logic compress);
		logic               spk;
		logic               mute;
		logic [1:0]         vol;
		logic [1:0]         mode;
		logic signed [15:0] syl;
		logic signed [15:0] syr;
		int                 burst;
		for (int i = 0; i < count; i++) begin
			set_sb(16'(rand_bits(16)), 16'(rand_bits(16)));
			burst = 1 + int'(rand_bits(2));
			for (int k = 0; k < burst; k++) begin
				spk  = 1'(rand_bits(1));
				vol  = 2'(rand_bits(2));
				syl  = 16'(rand_bits(16));
				syr  = 16'(rand_bits(16));
				mute = 1'(rand_bits(1));
				mode = compress ? 2'(rand_bits(2)) : 2'd0;
				if (compress && mode == 2'd0) mode = 2'd1;
				strobe_one(spk, vol, syl, syr, mute, mode,
					model_pair(spk, vol, syl, syr, mute, mode));
			end
			end_strobes();
			drain();
		end
	endtask

	// Samples just around a knee, both signs, all three curves
	task automatic knee_sweep(input int knee);
		for (int v = knee - 1; v <= knee + 1; v++) begin
			set_sb(16'(v), 16'(-v));
			for (int m = 1; m < 4; m++) begin
				strobe_one(1'b0, 2'd0, 16'sd0, 16'sd0, 1'b0, 2'(m),
					model_pair(1'b0, 2'd0, 16'sd0, 16'sd0, 1'b0, 2'(m)));
			end
			end_strobes();
			drain();
		end
	endtask

	// One-cycle glitch while strobes run, the mix must keep the old pair
	task automatic glitch_test(input logic signed [15:0] gl, input logic signed [15:0] gr);
		set_sb(16'(rand_bits(16)), 16'(rand_bits(16)));
		for (int i = 0; i < 8; i++) begin
			strobe_one(1'b0, 2'd0, 16'sd0, 16'sd0, 1'b0, 2'd0,
				model_pair(1'b0, 2'd0, 16'sd0, 16'sd0, 1'b0, 2'd0));
			if (i == 1) begin
				sb_left  <= gl;
				sb_right <= gr;
			end else if (i == 2) begin
				sb_left  <= model_sb_l;
				sb_right <= model_sb_r;
			end
		end
		end_strobes();
		drain();
	endtask

	//////////////////////////////////////////////////
	// Output monitor
	//////////////////////////////////////////////////

	always @(posedge clk_sys) begin
		logic [31:0] expected;
		if (reset) begin
			strobe_hist <= '0;
			last_left   <= '0;
			last_right  <= '0;
		end else begin
			strobe_hist <= {strobe_hist[1:0], mix_strobe};
			if (audio_strobe !== strobe_hist[2]) begin
				mon_errors++;
				$display("Error audio_strobe expected %h got %h", strobe_hist[2], audio_strobe);
			end
			if (audio_strobe && exp_q.size() == 0) begin
				mon_errors++;
				$display("Output strobe with no sample pending");
			end else if (audio_strobe) begin
				expected = exp_q.pop_front();
				if (audio_left !== expected[31:16]) begin
					mon_errors++;
					$display("Error audio_left expected %h got %h", expected[31:16], audio_left);
				end
				if (audio_right !== expected[15:0]) begin
					mon_errors++;
					$display("Error audio_right expected %h got %h", expected[15:0], audio_right);
				end
			end else begin
				// Outputs hold between strobes
				if (audio_left !== last_left) begin
					mon_errors++;
					$display("Error audio_left expected %h got %h", last_left, audio_left);
				end
				if (audio_right !== last_right) begin
					mon_errors++;
					$display("Error audio_right expected %h got %h", last_right, audio_right);
				end
			end
			last_left  <= audio_left;
			last_right <= audio_right;
		end
	end

	initial begin
		clk_sys        = 1'b0;
		reset          = 1'b1;
		sb_left        = '0;
		sb_right       = '0;
		speaker        = 1'b0;
		speaker_volume = '0;
		synth_left     = '0;
		synth_right    = '0;
		synth_mute     = 1'b0;
		comp_mode      = '0;
		mix_strobe     = 1'b0;
		lfsr           = 16'(SEED);
		model_sb_l     = '0;
		model_sb_r     = '0;
		errors         = 0;
		mon_errors     = 0;
		timeouts       = 0;

		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);
		if (audio_strobe !== 1'b0) begin
			errors++;
			$display("Error audio_strobe expected %h got %h", 1'b0, audio_strobe);
		end
		if (audio_left !== 16'h0) begin
			errors++;
			$display("Error audio_left expected %h got %h", 16'h0, audio_left);
		end
		if (audio_right !== 16'h0) begin
			errors++;
			$display("Error audio_right expected %h got %h", 16'h0, audio_right);
		end

		random_mixes(40, 1'b0);

		// Saturation at both rails
		set_sb(16'sh7000, 16'sh8000);
		strobe_one(1'b1, 2'd0, 16'sh7000, 16'sh8000, 1'b0, 2'd0, {16'h7FFF, 16'h8000});
		strobe_one(1'b1, 2'd3, 16'sh7000, 16'sh8000, 1'b1, 2'd0,
			model_pair(1'b1, 2'd3, 16'sh7000, 16'sh8000, 1'b1, 2'd0));
		strobe_one(1'b1, 2'd0, 16'sh7000, 16'sh8000, 1'b0, 2'd2,
			model_pair(1'b1, 2'd0, 16'sh7000, 16'sh8000, 1'b0, 2'd2));
		end_strobes();
		drain();

		knee_sweep(`COMP_LIGHT_X);
		knee_sweep(`COMP_HEAVY_X);
		random_mixes(40, 1'b1);
		glitch_test(16'sh5A5A, -16'sh1234);
		glitch_test(16'sh8000, 16'sh7FFF);

		repeat (5) @(posedge clk_sys);
		$display("Errors: %0d, timeouts: %0d", errors + mon_errors, timeouts);
		if (errors + mon_errors == 0 && timeouts == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hw
hw/audio_pkg.sv
hw/mix_stage_if.sv
hw/sample_sync.sv
hw/audio_mixer.sv
hw/dynamic_compressor.sv
hw/audio_out_top.sv
bench/tb_audio_out.sv

// File: hw/audio_cfg.svh
// Audio path configuration
`ifndef AUDIO_CFG_SVH
`define AUDIO_CFG_SVH

// Sample widths
`define AUDIO_SAMPLE_W 16
`define AUDIO_SUM_W 17

// Speaker bit lands at 2048, times 1, 2, 4 or 8 by volume
`define AUDIO_SPK_SHIFT 11

//////////////////////////////////////////////////
// Compressor curves
//////////////////////////////////////////////////

// Light curve, slope 1/4 above the knee, gain 2 below it
`define COMP_LIGHT_F 4
`define COMP_LIGHT_A 2
`define COMP_LIGHT_X 10923
`define COMP_LIGHT_B (`COMP_LIGHT_X * `COMP_LIGHT_A)

// Heavy curve, slope 1/8 above the knee, gain 4 below it
`define COMP_HEAVY_F 8
`define COMP_HEAVY_A 4
`define COMP_HEAVY_X 7399
`define COMP_HEAVY_B (`COMP_HEAVY_X * `COMP_HEAVY_A)

`endif

// File: hw/audio_mixer.sv
// Three-source audio mixer
`timescale 1ns/10ps
`default_nettype none

`include "audio_cfg.svh"

module audio_mixer (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  mix_strobe,
	input  audio_pkg::sample_t    sb_left,
	input  audio_pkg::sample_t    sb_right,
	input  logic                  speaker,
	input  audio_pkg::spk_vol_t   speaker_volume,
	input  audio_pkg::sample_t    synth_left,
	input  audio_pkg::sample_t    synth_right,
	input  logic                  synth_mute,
	input  audio_pkg::comp_mode_t comp_mode,
	mix_stage_if.source           stage
);

	audio_pkg::sum_t       spk_term;
	audio_pkg::sum_t       synth_l;
	audio_pkg::sum_t       synth_r;
	audio_pkg::sum_t       sum_l;
	audio_pkg::sum_t       sum_r;
	logic                  sum_vld;
	audio_pkg::comp_mode_t sum_mode;

	// Clip the 17-bit sum to the 16-bit range
	function automatic audio_pkg::sample_t saturate(input audio_pkg::sum_t s);
		if (s[`AUDIO_SUM_W-1] != s[`AUDIO_SUM_W-2]) begin
			return {s[`AUDIO_SUM_W-1], {(`AUDIO_SAMPLE_W-1){~s[`AUDIO_SUM_W-1]}}};
		end
		return s[`AUDIO_SAMPLE_W-1:0];
	endfunction

	////////////////////////////////////////////////
	// Source terms
	////////////////////////////////////////////////

	// Speaker is a single bit, volume doubles its step
	always_comb begin
		spk_term = '0;
		if (speaker) begin
			spk_term = (audio_pkg::sum_t'(1) << speaker_volume) << `AUDIO_SPK_SHIFT;
		end
	end

	assign synth_l = synth_mute ? '0 : audio_pkg::sum_t'(synth_left);
	assign synth_r = synth_mute ? '0 : audio_pkg::sum_t'(synth_right);

	////////////////////////////////////////////////
	// Sum stage
	////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sum_vld <= 1'b0;
		end else begin
			sum_vld <= mix_strobe;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (mix_strobe) begin
			sum_l    <= audio_pkg::sum_t'(sb_left) + spk_term + synth_l;
			sum_r    <= audio_pkg::sum_t'(sb_right) + spk_term + synth_r;
			sum_mode <= comp_mode;
		end
	end

	////////////////////////////////////////////////
	// Clamp stage
	////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			stage.strobe <= 1'b0;
		end else begin
			stage.strobe <= sum_vld;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sum_vld) begin
			stage.left  <= saturate(sum_l);
			stage.right <= saturate(sum_r);
			stage.mode  <= sum_mode;
		end
	end

	// Two register stages between request and clamped sample
	a_stage_latency : assert property (@(posedge clk_sys) disable iff (reset)
		mix_strobe |-> ##2 stage.strobe);

endmodule

`default_nettype wire

// File: hw/audio_out_top.sv
// Audio output path top
`timescale 1ns/10ps
`default_nettype none

`include "audio_cfg.svh"

module audio_out_top (
	input  logic                             clk_sys,
	input  logic                             reset,
	// Sound card pair, changes on its own timing
	input  logic signed [`AUDIO_SAMPLE_W-1:0] sb_left,
	input  logic signed [`AUDIO_SAMPLE_W-1:0] sb_right,
	input  logic                             speaker,
	input  logic [1:0]                       speaker_volume,
	input  logic signed [`AUDIO_SAMPLE_W-1:0] synth_left,
	input  logic signed [`AUDIO_SAMPLE_W-1:0] synth_right,
	input  logic                             synth_mute,
	input  logic [1:0]                       comp_mode,
	input  logic                             mix_strobe,
	output logic signed [`AUDIO_SAMPLE_W-1:0] audio_left,
	output logic signed [`AUDIO_SAMPLE_W-1:0] audio_right,
	output logic                             audio_strobe
);

	logic signed [`AUDIO_SAMPLE_W-1:0] sb_held_left;
	logic signed [`AUDIO_SAMPLE_W-1:0] sb_held_right;

	mix_stage_if i_stage ();

	sample_sync i_sample_sync (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.in_left    (sb_left),
		.in_right   (sb_right),
		.held_left  (sb_held_left),
		.held_right (sb_held_right)
	);

	audio_mixer i_audio_mixer (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.mix_strobe     (mix_strobe),
		.sb_left        (sb_held_left),
		.sb_right       (sb_held_right),
		.speaker        (speaker),
		.speaker_volume (speaker_volume),
		.synth_left     (synth_left),
		.synth_right    (synth_right),
		.synth_mute     (synth_mute),
		.comp_mode      (audio_pkg::comp_mode_t'(comp_mode)),
		.stage          (i_stage)
	);

	dynamic_compressor i_dynamic_compressor (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.stage        (i_stage),
		.audio_left   (audio_left),
		.audio_right  (audio_right),
		.audio_strobe (audio_strobe)
	);

endmodule

`default_nettype wire

// File: hw/audio_pkg.sv
// Audio path types
`default_nettype none

`include "audio_cfg.svh"

package audio_pkg;

	// Signed PCM sample as it leaves the mixer
	typedef logic signed [`AUDIO_SAMPLE_W-1:0] sample_t;

	// One guard bit for the three-way sum
	typedef logic signed [`AUDIO_SUM_W-1:0] sum_t;

	// PC speaker volume, 0 is quietest
	typedef logic [1:0] spk_vol_t;

	// Compressor curve select
	typedef enum logic [1:0] {
		COMP_OFF       = 2'd0,
		COMP_LIGHT     = 2'd1,
		COMP_HEAVY     = 2'd2,
		COMP_HEAVY_ALT = 2'd3
	} comp_mode_t;

endpackage

`default_nettype wire

// File: hw/dynamic_compressor.sv
// Dynamic range compressor
`timescale 1ns/10ps
`default_nettype none

`include "audio_cfg.svh"

module dynamic_compressor (
	input  logic               clk_sys,
	input  logic               reset,
	mix_stage_if.sink          stage,
	output audio_pkg::sample_t audio_left,
	output audio_pkg::sample_t audio_right,
	output logic               audio_strobe
);

	// Piecewise-linear curve on the magnitude, sign restored afterwards
	function automatic audio_pkg::sample_t compress(
		input audio_pkg::sample_t    s,
		input audio_pkg::comp_mode_t m
	);
		logic [`AUDIO_SAMPLE_W-1:0] mag;
		logic [`AUDIO_SAMPLE_W-1:0] light;
		logic [`AUDIO_SAMPLE_W-1:0] heavy;
		logic [`AUDIO_SAMPLE_W-1:0] curved;

		// Full-scale negative gives 32768, still fits unsigned
		mag = s[`AUDIO_SAMPLE_W-1] ? 16'(-s) : 16'(s);

		if (mag < 16'(`COMP_LIGHT_X)) begin
			light = 16'(mag * 16'(`COMP_LIGHT_A));
		end else begin
			light = 16'((mag - 16'(`COMP_LIGHT_X)) / 16'(`COMP_LIGHT_F)) +
				16'(`COMP_LIGHT_B);
		end

		if (mag < 16'(`COMP_HEAVY_X)) begin
			heavy = 16'(mag * 16'(`COMP_HEAVY_A));
		end else begin
			heavy = 16'((mag - 16'(`COMP_HEAVY_X)) / 16'(`COMP_HEAVY_F)) +
				16'(`COMP_HEAVY_B);
		end

		case (m)
			audio_pkg::COMP_OFF:   return s;
			audio_pkg::COMP_LIGHT: curved = light;
			default:               curved = heavy;
		endcase

		return s[`AUDIO_SAMPLE_W-1] ? audio_pkg::sample_t'(-curved) : audio_pkg::sample_t'(curved);
	endfunction

	//////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_strobe <= 1'b0;
			audio_left   <= '0;
			audio_right  <= '0;
		end else begin
			audio_strobe <= stage.strobe;
			// Hold the last pair between strobes
			if (stage.strobe) begin
				audio_left  <= compress(stage.left, stage.mode);
				audio_right <= compress(stage.right, stage.mode);
			end
		end
	end

	// Back-to-back outputs only from back-to-back stage samples
	a_no_extra_strobe : assert property (@(posedge clk_sys) disable iff (reset)
		(audio_strobe && $past(audio_strobe)) |->
			($past(stage.strobe) && $past(stage.strobe, 2)));

endmodule

`default_nettype wire

// File: hw/mix_stage_if.sv
// Mixer to compressor stage
`timescale 1ns/10ps
`default_nettype none

interface mix_stage_if;

	// One-cycle strobe, no back-pressure
	logic strobe;

	// Clamped stereo pair, valid with strobe
	audio_pkg::sample_t left;
	audio_pkg::sample_t right;

	// Curve for this sample
	audio_pkg::comp_mode_t mode;

	modport source (
		output strobe,
		output left,
		output right,
		output mode
	);

	modport sink (
		input strobe,
		input left,
		input right,
		input mode
	);

endinterface

`default_nettype wire

// File: hw/sample_sync.sv
// Sound card sample filter
`timescale 1ns/10ps
`default_nettype none

module sample_sync (
	input  logic               clk_sys,
	input  logic               reset,
	input  audio_pkg::sample_t in_left,
	input  audio_pkg::sample_t in_right,
	output audio_pkg::sample_t held_left,
	output audio_pkg::sample_t held_right
);

	// Index 0 is left, 1 is right
	audio_pkg::sample_t in_ch   [2];
	audio_pkg::sample_t stage_a [2];
	audio_pkg::sample_t stage_b [2];
	audio_pkg::sample_t held    [2];

	assign in_ch[0]   = in_left;
	assign in_ch[1]   = in_right;
	assign held_left  = held[0];
	assign held_right = held[1];

	// Take a word only once two samples in a row agree
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			for (int i = 0; i < 2; i++) begin
				stage_a[i] <= '0;
				stage_b[i] <= '0;
				held[i]    <= '0;
			end
		end else begin
			for (int i = 0; i < 2; i++) begin
				stage_a[i] <= in_ch[i];
				stage_b[i] <= stage_a[i];
				if (stage_a[i] == stage_b[i]) begin
					held[i] <= stage_b[i];
				end
			end
		end
	end

	genvar ch;
	for (ch = 0; ch < 2; ch++) begin : g_chk
		// A new held word sat on the input for two cycles in a row
		a_held_tracks : assert property (@(posedge clk_sys) disable iff (reset)
			(held[ch] != $past(held[ch])) |->
				((held[ch] == $past(in_ch[ch], 3)) &&
				($past(in_ch[ch], 2) == $past(in_ch[ch], 3))));
	end

endmodule

`default_nettype wire
